// ==== hdl/alu_unit.sv ====
/*
 * Single-cycle integer ALU. Executes the issued operation and
 * drives the registered result onto the common data bus
 */
`timescale 1ns/1ps

module alu_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  ooo_pkg::issue_pkt_t issue,
    output ooo_pkg::cdb_pkt_t   cdb
);

    logic [ooo_pkg::xlen-1:0] result;
    logic [4:0]               shamt;

    // Shift amount from the low bits of b
    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            ooo_pkg::alu_add: result = issue.a + issue.b;
            ooo_pkg::alu_sub: result = issue.a - issue.b;
            ooo_pkg::alu_and: result = issue.a & issue.b;
            ooo_pkg::alu_or:  result = issue.a | issue.b;
            ooo_pkg::alu_xor: result = issue.a ^ issue.b;
            ooo_pkg::alu_sll: result = issue.a << shamt;
            ooo_pkg::alu_srl: result = issue.a >> shamt;
            ooo_pkg::alu_slt: begin
                result = '0;
                result[0] = $signed(issue.a) < $signed(issue.b);
            end
            default: result = '0;
        endcase
    end

    // One-cycle valid per issued operation
    always_ff @(posedge clk) begin
        if (reset || flush)
            cdb.valid <= 1'b0;
        else
            cdb.valid <= issue.valid;
    end

    always_ff @(posedge clk) begin
        cdb.tag <= issue.dest_tag;
        cdb.result <= result;
    end

endmodule

// ==== hdl/dispatch_unit.sv ====
/*
 * Dispatch unit. Decodes the instruction word, renames sources
 * through the register status table, allocates a tag and a free
 * station, and retires bus results into the register file
 */
`timescale 1ns/1ps

module dispatch_unit #(
    parameter int num_rs = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          instr_valid,
    input  ooo_pkg::instr_u               instr,
    input  logic [num_rs-1:0]             rs_busy,
    input  ooo_pkg::cdb_pkt_t             cdb,
    output logic                          ready,
    output logic [ooo_pkg::tag_w-1:0]     dispatch_tag,
    output logic [num_rs-1:0]             wr_sel,
    output ooo_pkg::rs_entry_t            wr_entry
);

    localparam logic [ooo_pkg::tag_w-1:0] first_tag = 1;

    logic [ooo_pkg::xlen-1:0]  regfile [ooo_pkg::num_regs];
    logic [ooo_pkg::tag_w-1:0] status  [ooo_pkg::num_regs];
    logic [ooo_pkg::max_tag:0] in_use;
    logic [ooo_pkg::tag_w-1:0] next_tag;

    logic [num_rs-1:0]         free_sel;
    logic                      found;
    logic                      accept;
    logic                      imm_form;
    logic [ooo_pkg::reg_w-1:0] dest;
    logic [ooo_pkg::reg_w-1:0] src1;
    logic [ooo_pkg::reg_w-1:0] src2;
    logic [ooo_pkg::tag_w-1:0] tag_j;
    logic [ooo_pkg::tag_w-1:0] tag_k;
    logic [ooo_pkg::xlen-1:0]  imm_ext;

    // Lowest free station
    always_comb begin
        free_sel = '0;
        found = 1'b0;
        for (int i = 0; i < num_rs; i++) begin
            if (!rs_busy[i] && !found) begin
                free_sel[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign ready = found && !in_use[next_tag] && !flush;
    assign accept = instr_valid && ready;
    assign dispatch_tag = next_tag;
    assign wr_sel = accept ? free_sel : '0;

    // Both forms keep the form bit, op, dest and src1 in the same place
    assign imm_form = instr.imm_form.form;
    assign dest = instr.reg_form.dest;
    assign src1 = instr.reg_form.src1;
    assign src2 = instr.reg_form.src2;
    assign imm_ext = {{(ooo_pkg::xlen - ooo_pkg::imm_w){instr.imm_form.imm[ooo_pkg::imm_w-1]}},
                      instr.imm_form.imm};

    assign tag_j = status[src1];
    assign tag_k = status[src2];

    // Rename sources and forward a result broadcast this cycle
    always_comb begin
        wr_entry.busy = 1'b1;
        wr_entry.op = instr.reg_form.op;
        wr_entry.dest_tag = next_tag;

        if (tag_j == '0) begin
            wr_entry.q_j = '0;
            wr_entry.v_j = regfile[src1];
        end else if (cdb.valid && cdb.tag == tag_j) begin
            wr_entry.q_j = '0;
            wr_entry.v_j = cdb.result;
        end else begin
            wr_entry.q_j = tag_j;
            wr_entry.v_j = '0;
        end

        if (imm_form || tag_k == '0) begin
            wr_entry.q_k = '0;
            wr_entry.v_k = imm_form ? imm_ext : regfile[src2];
        end else if (cdb.valid && cdb.tag == tag_k) begin
            wr_entry.q_k = '0;
            wr_entry.v_k = cdb.result;
        end else begin
            wr_entry.q_k = tag_k;
            wr_entry.v_k = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < ooo_pkg::num_regs; r++) begin
                regfile[r] <= '0;
                status[r] <= '0;
            end
            in_use <= '0;
            next_tag <= first_tag;
        end else begin
            // Retire only if the writer is still the latest for that register
            for (int r = 0; r < ooo_pkg::num_regs; r++) begin
                if (cdb.valid && status[r] == cdb.tag) begin
                    regfile[r] <= cdb.result;
                    status[r] <= '0;
                end
            end
            if (cdb.valid)
                in_use[cdb.tag] <= 1'b0;

            if (flush) begin
                for (int r = 0; r < ooo_pkg::num_regs; r++)
                    status[r] <= '0;
                in_use <= '0;
            end else if (accept) begin
                status[dest] <= next_tag;
                in_use[next_tag] <= 1'b1;
                next_tag <= (next_tag == '1) ? first_tag : next_tag + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/ooo_issue_top.sv ====
/*
 * Issue stage top. Dispatch feeds the reservation stations,
 * which issue to the ALU that broadcasts on the common data bus
 */
`timescale 1ns/1ps

module ooo_issue_top #(
    parameter int num_rs = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      instr_valid,
    input  ooo_pkg::instr_u           instr,
    output logic                      ready,
    output logic [ooo_pkg::tag_w-1:0] dispatch_tag,
    output ooo_pkg::cdb_pkt_t         cdb,
    output logic [num_rs-1:0]         rs_busy
);

    logic [num_rs-1:0]   wr_sel;
    ooo_pkg::rs_entry_t  wr_entry;
    ooo_pkg::issue_pkt_t issue;

    dispatch_unit #(.num_rs(num_rs)) u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs_busy      (rs_busy),
        .cdb          (cdb),
        .ready        (ready),
        .dispatch_tag (dispatch_tag),
        .wr_sel       (wr_sel),
        .wr_entry     (wr_entry)
    );

    rs_array #(.num_rs(num_rs)) u_rs_array (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .wr_sel   (wr_sel),
        .wr_entry (wr_entry),
        .cdb      (cdb),
        .rs_busy  (rs_busy),
        .issue    (issue)
    );

    alu_unit u_alu (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

// ==== hdl/ooo_pkg.sv ====
/*
 * Shared definitions for the out-of-order issue stage
 * Widths, ALU opcodes, the instruction word union and the
 * station, issue and common data bus records
 */
package ooo_pkg;

    // Datapath and naming widths
    localparam int xlen = 32;
    localparam int tag_w = 4;
    localparam int reg_w = 3;
    localparam int num_regs = 2 ** reg_w;

    // Tag 0 is reserved for "value present"
    localparam int max_tag = 2 ** tag_w - 1;

    // Immediate field width in the 16-bit immediate form
    localparam int imm_w = 6;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_op_e;

    // Register form, form bit = 0
    typedef struct packed {
        logic             form;
        alu_op_e          op;
        logic [reg_w-1:0] dest;
        logic [reg_w-1:0] src1;
        logic [reg_w-1:0] src2;
        logic [2:0]       pad;
    } instr_reg_t;

    // Immediate form, form bit = 1
    typedef struct packed {
        logic             form;
        alu_op_e          op;
        logic [reg_w-1:0] dest;
        logic [reg_w-1:0] src1;
        logic [imm_w-1:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t reg_form;
        instr_imm_t imm_form;
    } instr_u;

    typedef struct packed {
        logic             busy;
        alu_op_e          op;
        logic [tag_w-1:0] dest_tag;
        logic [tag_w-1:0] q_j;
        logic [tag_w-1:0] q_k;
        logic [xlen-1:0]  v_j;
        logic [xlen-1:0]  v_k;
    } rs_entry_t;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        logic [tag_w-1:0] dest_tag;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
    } issue_pkt_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  result;
    } cdb_pkt_t;

endpackage

// ==== hdl/rs_array.sv ====
/*
 * Reservation station array. Writes the selected station,
 * picks the lowest-index ready station and registers its issue
 */
`timescale 1ns/1ps

module rs_array #(
    parameter int num_rs = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic [num_rs-1:0]  wr_sel,
    input  ooo_pkg::rs_entry_t wr_entry,
    input  ooo_pkg::cdb_pkt_t  cdb,
    output logic [num_rs-1:0]  rs_busy,
    output ooo_pkg::issue_pkt_t issue
);

    ooo_pkg::rs_entry_t entries [num_rs];
    ooo_pkg::rs_entry_t pick_entry;
    logic [num_rs-1:0]  ready_op;
    logic [num_rs-1:0]  take;
    logic               any_ready;

    for (genvar i = 0; i < num_rs; i++) begin : g_rs
        rs_station u_station (
            .clk      (clk),
            .reset    (reset),
            .flush    (flush),
            .wr_en    (wr_sel[i]),
            .wr_entry (wr_entry),
            .cdb      (cdb),
            .take     (take[i]),
            .entry    (entries[i]),
            .ready_op (ready_op[i])
        );
        assign rs_busy[i] = entries[i].busy;
    end

    // Lowest index wins
    always_comb begin
        take = '0;
        any_ready = 1'b0;
        pick_entry = entries[0];
        for (int i = 0; i < num_rs; i++) begin
            if (ready_op[i] && !any_ready) begin
                take[i] = 1'b1;
                any_ready = 1'b1;
                pick_entry = entries[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            issue.valid <= 1'b0;
        else
            issue.valid <= any_ready;
    end

    always_ff @(posedge clk) begin
        issue.op <= pick_entry.op;
        issue.dest_tag <= pick_entry.dest_tag;
        issue.a <= pick_entry.v_j;
        issue.b <= pick_entry.v_k;
    end

endmodule

// ==== hdl/rs_station.sv ====
/*
 * Single reservation station. Holds one operation and
 * captures missing operands from the common data bus
 */
`timescale 1ns/1ps

module rs_station (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               wr_en,
    input  ooo_pkg::rs_entry_t wr_entry,
    input  ooo_pkg::cdb_pkt_t  cdb,
    input  logic               take,
    output ooo_pkg::rs_entry_t entry,
    output logic               ready_op
);

    logic hit_j;
    logic hit_k;

    // Tag 0 never matches, so a present operand is left alone
    assign hit_j = cdb.valid && entry.q_j != '0 && entry.q_j == cdb.tag;
    assign hit_k = cdb.valid && entry.q_k != '0 && entry.q_k == cdb.tag;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            entry.busy <= 1'b0;
            entry.q_j <= '0;
            entry.q_k <= '0;
        end else if (wr_en) begin
            entry.busy <= wr_entry.busy;
            entry.q_j <= wr_entry.q_j;
            entry.q_k <= wr_entry.q_k;
        end else begin
            if (take)
                entry.busy <= 1'b0;
            if (hit_j)
                entry.q_j <= '0;
            if (hit_k)
                entry.q_k <= '0;
        end
    end

    // Operation and operand values
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry.op <= wr_entry.op;
            entry.dest_tag <= wr_entry.dest_tag;
            entry.v_j <= wr_entry.v_j;
            entry.v_k <= wr_entry.v_k;
        end else begin
            if (hit_j)
                entry.v_j <= cdb.result;
            if (hit_k)
                entry.v_k <= cdb.result;
        end
    end

    assign ready_op = entry.busy && entry.q_j == '0 && entry.q_k == '0;

endmodule

// ==== ooo_issue.f ====
+incdir+tb
hdl/ooo_pkg.sv
hdl/rs_station.sv
hdl/rs_array.sv
hdl/dispatch_unit.sv
hdl/alu_unit.sv
hdl/ooo_issue_top.sv
tb/ooo_issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the issue stage testbench with Verilator, run it, and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module ooo_issue_tb -f ooo_issue.f -o ooo_issue_sim \
    > sim.log 2>&1 \
    && ./obj_dir/ooo_issue_sim >> sim.log 2>&1 \
    || echo "Checks failed" >> sim.log
grep -q "Checks failed" sim.log && echo "FAIL, see sim.log" && exit 1
grep -q "All checks passed" sim.log || exit 1
echo "PASS"

// ==== tb/ooo_issue_model.svh ====
/*
 * Reference model for the issue stage testbench
 * ALU function, in-order register shadow, xorshift and value check
 */
`ifndef OOO_ISSUE_MODEL_SVH
`define OOO_ISSUE_MODEL_SVH

// In-order value of each register with results still in flight
logic [31:0] shadow    [8];
// Register file contents as written from the bus
logic [31:0] committed [8];
logic [3:0]  writer    [8];
logic [31:0] expected  [16];
logic        pending   [16];
logic [3:0]  model_tag;

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Opcodes in the order add, sub, and, or, xor, sll, srl, slt
function automatic logic [31:0] expected_alu(input logic [2:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
        3'd0: return a + b;
        3'd1: return a - b;
        3'd2: return a & b;
        3'd3: return a | b;
        3'd4: return a ^ b;
        3'd5: return a << b[4:0];
        3'd6: return a >> b[4:0];
        default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
endfunction

task automatic compare_values(input logic [31:0] actual, input logic [31:0] want,
                              input string what);
    if (actual !== want)
        stop_with_failure($sformatf("Mismatch at %0d ns: %s, got %0h, expected %0h",
                                    $time, what, actual, want));
endtask

task automatic reset_model();
    for (int r = 0; r < 8; r++) begin
        shadow[r] = 32'd0;
        committed[r] = 32'd0;
        writer[r] = 4'd0;
    end
    for (int t = 0; t < 16; t++) begin
        expected[t] = 32'd0;
        pending[t] = 1'b0;
    end
    model_tag = 4'd1;
endtask

task automatic record_dispatch(input logic form, input logic [2:0] op, input logic [2:0] dest,
                               input logic [2:0] src1, input logic [2:0] src2,
                               input logic [ooo_pkg::imm_w-1:0] imm);
    logic [31:0] b;
    b = form ? {{(32 - ooo_pkg::imm_w){imm[ooo_pkg::imm_w-1]}}, imm} : shadow[src2];
    expected[model_tag] = expected_alu(op, shadow[src1], b);
    pending[model_tag] = 1'b1;
    writer[dest] = model_tag;
    shadow[dest] = expected[model_tag];
    model_tag = (model_tag == 4'd15) ? 4'd1 : model_tag + 4'd1;
endtask

// A result reaches the register only while its tag is the latest writer
task automatic retire_result(input logic [3:0] t, input logic [31:0] v);
    compare_values(32'(pending[t]), 32'd1, "bus tag without a live allocation");
    compare_values(v, expected[t], $sformatf("result of tag %0d", t));
    pending[t] = 1'b0;
    for (int r = 0; r < 8; r++) begin
        if (writer[r] == t) begin
            committed[r] = v;
            writer[r] = 4'd0;
        end
    end
endtask

task automatic clear_speculation();
    for (int r = 0; r < 8; r++) begin
        shadow[r] = committed[r];
        writer[r] = 4'd0;
    end
    for (int t = 0; t < 16; t++)
        pending[t] = 1'b0;
endtask

`endif

// ==== tb/ooo_issue_tb.sv ====
/*
 * Testbench for the issue stage. Directed and random instruction
 * streams are checked against an in-order reference model
 */
`timescale 1ns/1ps

module ooo_issue_tb;

    localparam int num_rs = 4;
    localparam int wait_limit = 300;

    logic                      clk;
    logic                      reset;
    logic                      flush;
    logic                      instr_valid;
    ooo_pkg::instr_u           instr;
    logic                      ready;
    logic [ooo_pkg::tag_w-1:0] dispatch_tag;
    ooo_pkg::cdb_pkt_t         cdb;
    logic [num_rs-1:0]         rs_busy;

    logic [31:0] rnd;
    logic        saw_stall;
    logic        saw_full = 1'b0;
    logic [3:0]  chain_tags [$];

    `include "ooo_issue_model.svh"

    ooo_issue_top #(.num_rs(num_rs)) ooo_issue_top_i (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .ready        (ready),
        .dispatch_tag (dispatch_tag),
        .cdb          (cdb),
        .rs_busy      (rs_busy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    // Waits for ready, optionally strobing while stalled, then sends one word
    task automatic dispatch_instr(input logic form, input logic [2:0] op, input logic [2:0] dest,
                                  input logic [2:0] src1, input logic [2:0] src2,
                                  input logic [31:0] imm, input logic strobe_stalled);
        int n;
        n = 0;
        @(negedge clk);
        instr_valid = 1'b0;
        if (form) begin
            instr.imm_form.form = 1'b1;
            instr.imm_form.op = ooo_pkg::alu_op_e'(op);
            instr.imm_form.dest = dest;
            instr.imm_form.src1 = src1;
            instr.imm_form.imm = imm[ooo_pkg::imm_w-1:0];
        end else begin
            instr.reg_form.form = 1'b0;
            instr.reg_form.op = ooo_pkg::alu_op_e'(op);
            instr.reg_form.dest = dest;
            instr.reg_form.src1 = src1;
            instr.reg_form.src2 = src2;
            instr.reg_form.pad = 3'd0;
        end
        while (!ready) begin
            saw_stall = 1'b1;
            instr_valid = strobe_stalled;
            n = n + 1;
            if (n > wait_limit)
                stop_with_failure("Timed out waiting for dispatch ready");
            @(negedge clk);
        end
        // An ignored strobe must not have moved the tag
        compare_values(32'(dispatch_tag), 32'(model_tag), "dispatch tag");
        instr_valid = 1'b1;
        @(posedge clk);
        record_dispatch(form, op, dest, src1, src2, imm[ooo_pkg::imm_w-1:0]);
    endtask

    task automatic send_random();
        rnd = xorshift(rnd);
        dispatch_instr(rnd[31], rnd[30:28], rnd[27:25], rnd[24:22], rnd[21:19], rnd, rnd[8]);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic wait_for_tag(input logic [3:0] t);
        int n;
        n = 0;
        @(posedge clk);
        while (pending[t]) begin
            n = n + 1;
            if (n > wait_limit)
                stop_with_failure($sformatf("Timed out waiting for tag %0d on the bus", t));
            @(posedge clk);
        end
    endtask

    task automatic drain_all();
        idle(1);
        for (int t = 1; t < 16; t++)
            wait_for_tag(4'(t));
    endtask

    // Or with immediate 0 returns each register as it stands
    task automatic read_all_regs();
        for (int r = 0; r < 8; r++)
            dispatch_instr(1'b1, 3'd3, 3'(r), 3'(r), 3'd0, 32'd0, 1'b0);
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        instr_valid = 1'b0;
        compare_values(32'(rs_busy != '0), 32'd1, "stations waiting before flush");
        flush = 1'b1;
        @(posedge clk);
        clear_speculation();
        @(negedge clk);
        flush = 1'b0;
        compare_values(32'(rs_busy), 32'd0, "rs_busy after flush");
        compare_values(32'(cdb.valid), 32'd0, "cdb valid after flush");
        @(negedge clk);
        compare_values(32'(ready), 32'd1, "ready after flush");
    endtask

    // Bus monitor and comparison
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && cdb.valid)
                retire_result(cdb.tag, cdb.result);
            if (!reset && rs_busy == '1)
                saw_full = 1'b1;
        end
    end

    initial begin
        rnd = 32'd23133;
        reset = 1'b1;
        flush = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        saw_stall = 1'b0;
        reset_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_values(32'(cdb.valid), 32'd0, "cdb valid after reset");
        compare_values(32'(rs_busy), 32'd0, "rs_busy after reset");
        compare_values(32'(ready), 32'd1, "ready after reset");
        compare_values(32'(dispatch_tag), 32'd1, "first tag after reset");
        read_all_regs();
        drain_all();

        // Dependent read at several distances, one lands on the broadcast cycle
        for (int k = 0; k < 5; k++) begin
            dispatch_instr(1'b1, 3'd0, 3'd2, 3'd3, 3'd0, 32'(k + 5), 1'b0);
            idle(k);
            dispatch_instr(1'b0, 3'd4, 3'd4, 3'd2, 3'd5, 32'd0, 1'b0);
            drain_all();
        end

        // Long chain on r1 fills the stations
        for (int i = 0; i < 20; i++) begin
            chain_tags.push_back(model_tag);
            dispatch_instr(1'b1, 3'd0, 3'd1, 3'd1, 3'd0, 32'd1, 1'b1);
        end
        idle(1);
        foreach (chain_tags[i])
            wait_for_tag(chain_tags[i]);
        compare_values(32'(saw_stall), 32'd1, "ready dropped during the chain");
        compare_values(32'(saw_full), 32'd1, "all stations busy during the chain");

        repeat (300) send_random();
        drain_all();

        // Flush a chain on r6 while entries still wait
        for (int i = 0; i < 6; i++) begin
            rnd = xorshift(rnd);
            dispatch_instr(1'b1, rnd[2:0], 3'd6, 3'd6, 3'd0, rnd >> 8, 1'b0);
        end
        pulse_flush();
        idle(6);
        read_all_regs();
        drain_all();

        repeat (150) send_random();
        drain_all();
        $display("All checks passed");
        $finish;
    end

endmodule
